// ==== microSystem_defines.svh ====
`ifndef MICROSYSTEM_DEFINES_SVH
`define MICROSYSTEM_DEFINES_SVH

// Data memory, byte range 0x0000 to 0x0FFF
`define DM_WORDS 1024
`define DM_ADDR_BITS 10
`define DM_BYTES (`DM_WORDS * 4)

// Timer windows, three words each
`define TIMER0_BASE 32'h0000_7F00
`define TIMER1_BASE 32'h0000_7F10
`define TIMER_WINDOW_WORDS 2'd3

// Word offsets inside a timer window
`define TIMER_CTRL 2'd0
`define TIMER_PRESET 2'd1
`define TIMER_COUNT 2'd2

// Control register fields
`define CTRL_BITS 4
`define CTRL_ENABLE 0
`define CTRL_MODE_LO 1
`define CTRL_MODE_HI 2
`define CTRL_IM 3

// Hardware interrupt vector, CPU cause bits 7:2
`define HWINT_BITS 6
`define HWINT_TIMER0 0
`define HWINT_TIMER1 1
`define HWINT_EXT 2

`endif

// ==== busPkg.sv ====
package busPkg;

    // Operation of one master request
    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } busOp;

    // North bridge sequence for one access
    typedef enum logic [1:0] {
        nbIdle    = 2'd0,
        nbAccess  = 2'd1,
        nbRespond = 2'd2
    } bridgeState;

    // Target of a decoded address
    typedef enum logic [1:0] {
        regionMem    = 2'd0,
        regionTimer0 = 2'd1,
        regionTimer1 = 2'd2,
        regionNone   = 2'd3
    } busRegion;

endpackage

// ==== timerPkg.sv ====
package timerPkg;

    // Mode field, control bits 2:1
    typedef enum logic [1:0] {
        modeOneShot = 2'b00,
        modeReload  = 2'b01
    } timerMode;

    typedef enum logic [1:0] {
        tIdle      = 2'd0,
        tLoad      = 2'd1,
        tCount     = 2'd2,
        tInterrupt = 2'd3
    } timerState;

endpackage

// ==== dataMem.sv ====
`include "microSystem_defines.svh"

module dataMem (
    input  logic        clk,
    input  logic        reset,
    input  logic [29:0] addr,
    input  logic [31:0] wData,
    input  logic [3:0]  byteEn,
    input  logic        write,
    output logic [31:0] rData
);

    logic [31:0]              mem [`DM_WORDS];
    logic [`DM_ADDR_BITS-1:0] index;

    assign index = addr[`DM_ADDR_BITS-1:0];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    mem[index][8*b +: 8] <= wData[8*b +: 8];
                end
            end
        end
    end

    // Read before write on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            rData <= '0;
        end else begin
            rData <= mem[index];
        end
    end

    // Bridge decode must keep writes inside the array
    assert property (@(posedge clk) disable iff (reset) write |-> (addr < `DM_WORDS));

endmodule

// ==== timer.sv ====
`include "microSystem_defines.svh"

module timer import timerPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  regOffset,
    input  logic [31:0] wData,
    input  logic        write,
    output logic [31:0] rData,
    output logic        irq
);

    timerState              state;
    timerMode               mode;
    logic [`CTRL_BITS-1:0]  ctrl;
    logic [31:0]            preset;
    logic [31:0]            count;
    logic                   irqHold;
    logic                   enable;
    logic                   intMask;
    logic                   ctrlWrite;
    logic                   presetWrite;

    assign mode        = timerMode'(ctrl[`CTRL_MODE_HI:`CTRL_MODE_LO]);
    assign enable      = ctrl[`CTRL_ENABLE];
    assign intMask     = ctrl[`CTRL_IM];
    assign ctrlWrite   = write && (regOffset == `TIMER_CTRL);
    assign presetWrite = write && (regOffset == `TIMER_PRESET);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= tIdle;
            ctrl    <= '0;
            preset  <= '0;
            count   <= '0;
            irqHold <= 1'b0;
        end else begin
            case (state)
                tLoad: begin
                    count <= preset;
                    state <= tCount;
                end
                tCount: begin
                    // Paused while enable is clear
                    if (enable) begin
                        if (count <= 32'd1) begin
                            count <= '0;
                            state <= tInterrupt;
                        end else begin
                            count <= count - 32'd1;
                        end
                    end
                end
                tInterrupt: begin
                    if (mode == modeReload) begin
                        count <= preset;
                        state <= tCount;
                    end else begin
                        ctrl[`CTRL_ENABLE] <= 1'b0;
                        irqHold            <= 1'b1;
                        state              <= tIdle;
                    end
                end
                default: state <= tIdle;
            endcase
            // Bus writes win over the FSM; count offset is read only
            if (ctrlWrite) begin
                ctrl    <= wData[`CTRL_BITS-1:0];
                irqHold <= 1'b0;
            end
            if (presetWrite) begin
                preset <= wData;
                state  <= tLoad;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rData <= '0;
        end else begin
            case (regOffset)
                `TIMER_CTRL:   rData <= {{(32-`CTRL_BITS){1'b0}}, ctrl};
                `TIMER_PRESET: rData <= preset;
                `TIMER_COUNT:  rData <= count;
                default:       rData <= '0;
            endcase
        end
    end

    // One pulse in reload mode, held until a ctrl write in one-shot mode
    assign irq = intMask && (irqHold || state == tInterrupt);

    assert property (@(posedge clk) disable iff (reset) (state != tLoad) |-> (count <= preset));

endmodule

// ==== northBridge.sv ====
`include "microSystem_defines.svh"

module northBridge import busPkg::*; (
    input  logic        clk,
    input  logic        reset,
    // Master port 0
    input  logic        reqValid0,
    output logic        reqReady0,
    input  busOp        reqOp0,
    input  logic [31:0] reqAddr0,
    input  logic [31:0] reqWData0,
    input  logic [3:0]  reqByteEn0,
    output logic        respValid0,
    input  logic        respReady0,
    output logic [31:0] respRData0,
    output logic        respError0,
    // Master port 1
    input  logic        reqValid1,
    output logic        reqReady1,
    input  busOp        reqOp1,
    input  logic [31:0] reqAddr1,
    input  logic [31:0] reqWData1,
    input  logic [3:0]  reqByteEn1,
    output logic        respValid1,
    input  logic        respReady1,
    output logic [31:0] respRData1,
    output logic        respError1,
    // Data memory
    output logic [29:0] memAddr,
    output logic [31:0] memWData,
    output logic [3:0]  memByteEn,
    output logic        memWrite,
    input  logic [31:0] memRData,
    // South bridge
    output busRegion    devRegion,
    output logic [1:0]  devOffset,
    output logic [31:0] devWData,
    output logic        devWrite,
    input  logic [31:0] devRData
);

    bridgeState  state;
    logic        lastGrant;
    logic        curPort;
    busOp        curOp;
    busRegion    curRegion;
    logic [31:0] curAddr;
    logic [31:0] curWData;
    logic [3:0]  curByteEn;
    logic        respFirst;
    logic [31:0] respHeld;
    logic [31:0] respLive;
    logic [31:0] respData;
    logic        isIdle;
    logic        bothValid;
    logic        grant0;
    logic        grant1;
    logic [31:0] pickAddr;
    logic        respHandshake;

    function automatic busRegion decodeRegion(input logic [31:0] addr);
        busRegion region;
        region = regionNone;
        if (addr < `DM_BYTES) begin
            region = regionMem;
        end else if (addr[3:2] < `TIMER_WINDOW_WORDS) begin
            if ({addr[31:4], 4'h0} == `TIMER0_BASE) begin
                region = regionTimer0;
            end else if ({addr[31:4], 4'h0} == `TIMER1_BASE) begin
                region = regionTimer1;
            end
        end
        return region;
    endfunction

    // Round robin, the port granted last yields when both compete
    assign isIdle    = (state == nbIdle);
    assign bothValid = reqValid0 && reqValid1;
    assign reqReady0 = isIdle && !(bothValid && !lastGrant);
    assign reqReady1 = isIdle && !(bothValid && lastGrant);
    assign grant0    = reqValid0 && reqReady0;
    assign grant1    = reqValid1 && reqReady1;
    assign pickAddr  = grant1 ? reqAddr1 : reqAddr0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= nbIdle;
            lastGrant <= 1'b1;
            curPort   <= 1'b0;
            curOp     <= opRead;
            curRegion <= regionNone;
            respFirst <= 1'b0;
        end else begin
            case (state)
                nbIdle: begin
                    if (grant0 || grant1) begin
                        state     <= nbAccess;
                        lastGrant <= grant1;
                        curPort   <= grant1;
                        curOp     <= grant1 ? reqOp1 : reqOp0;
                        curRegion <= decodeRegion(pickAddr);
                    end
                end
                nbAccess: begin
                    state     <= nbRespond;
                    respFirst <= 1'b1;
                end
                nbRespond: begin
                    respFirst <= 1'b0;
                    if (respHandshake) begin
                        state <= nbIdle;
                    end
                end
                default: state <= nbIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant0 || grant1) begin
            curAddr   <= pickAddr;
            curWData  <= grant1 ? reqWData1 : reqWData0;
            curByteEn <= grant1 ? reqByteEn1 : reqByteEn0;
        end
        // Device read data keeps moving, so freeze it after the first cycle
        if (respFirst) begin
            respHeld <= respLive;
        end
    end

    always_comb begin
        if (curOp == opWrite || curRegion == regionNone) begin
            respLive = '0;
        end else if (curRegion == regionMem) begin
            respLive = memRData;
        end else begin
            respLive = devRData;
        end
    end

    assign respData      = respFirst ? respLive : respHeld;
    assign respHandshake = curPort ? respReady1 : respReady0;
    assign respValid0    = (state == nbRespond) && !curPort;
    assign respValid1    = (state == nbRespond) && curPort;
    assign respRData0    = respValid0 ? respData : '0;
    assign respRData1    = respValid1 ? respData : '0;
    assign respError0    = respValid0 && (curRegion == regionNone);
    assign respError1    = respValid1 && (curRegion == regionNone);

    // Access strobes live for the single nbAccess cycle
    assign memAddr   = curAddr[31:2];
    assign memWData  = curWData;
    assign memByteEn = curByteEn;
    assign memWrite  = (state == nbAccess) && (curOp == opWrite) && (curRegion == regionMem);
    assign devRegion = curRegion;
    assign devOffset = curAddr[3:2];
    assign devWData  = curWData;
    assign devWrite  = (state == nbAccess) && (curOp == opWrite)
                       && (curRegion inside {regionTimer0, regionTimer1});

    assert property (@(posedge clk) disable iff (reset) !(respValid0 && respValid1));
    assert property (@(posedge clk) disable iff (reset)
        (state != nbIdle) |-> !(reqReady0 || reqReady1));
    assert property (@(posedge clk) disable iff (reset) !(memWrite && devWrite));

endmodule

// ==== southBridge.sv ====
`include "microSystem_defines.svh"

module southBridge import busPkg::*; (
    input  busRegion                devRegion,
    input  logic [1:0]              devOffset,
    input  logic [31:0]             devWData,
    input  logic                    devWrite,
    output logic [31:0]             devRData,
    // Timer 0
    output logic [1:0]              timer0Offset,
    output logic [31:0]             timer0WData,
    output logic                    timer0Write,
    input  logic [31:0]             timer0RData,
    input  logic                    timer0Irq,
    // Timer 1
    output logic [1:0]              timer1Offset,
    output logic [31:0]             timer1WData,
    output logic                    timer1Write,
    input  logic [31:0]             timer1RData,
    input  logic                    timer1Irq,
    // Interrupts
    input  logic                    extInterrupt,
    output logic [`HWINT_BITS-1:0]  hwInt
);

    // Offset and data are shared, the write strobe selects the device
    assign timer0Offset = devOffset;
    assign timer0WData  = devWData;
    assign timer0Write  = devWrite && (devRegion == regionTimer0);
    assign timer1Offset = devOffset;
    assign timer1WData  = devWData;
    assign timer1Write  = devWrite && (devRegion == regionTimer1);

    always_comb begin
        case (devRegion)
            regionTimer0: devRData = timer0RData;
            regionTimer1: devRData = timer1RData;
            default:      devRData = '0;
        endcase
    end

    // Unused vector bits stay low
    always_comb begin
        hwInt                = '0;
        hwInt[`HWINT_TIMER0] = timer0Irq;
        hwInt[`HWINT_TIMER1] = timer1Irq;
        hwInt[`HWINT_EXT]    = extInterrupt;
    end

endmodule

// ==== microSystem.sv ====
`include "microSystem_defines.svh"

module microSystem import busPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    extInterrupt,
    output logic [`HWINT_BITS-1:0]  hwInt,
    // Master port 0
    input  logic                    reqValid0,
    output logic                    reqReady0,
    input  busOp                    reqOp0,
    input  logic [31:0]             reqAddr0,
    input  logic [31:0]             reqWData0,
    input  logic [3:0]              reqByteEn0,
    output logic                    respValid0,
    input  logic                    respReady0,
    output logic [31:0]             respRData0,
    output logic                    respError0,
    // Master port 1
    input  logic                    reqValid1,
    output logic                    reqReady1,
    input  busOp                    reqOp1,
    input  logic [31:0]             reqAddr1,
    input  logic [31:0]             reqWData1,
    input  logic [3:0]              reqByteEn1,
    output logic                    respValid1,
    input  logic                    respReady1,
    output logic [31:0]             respRData1,
    output logic                    respError1
);

    // Bridge to memory
    logic [29:0] memAddr;
    logic [31:0] memWData;
    logic [3:0]  memByteEn;
    logic        memWrite;
    logic [31:0] memRData;

    // Bridge to devices
    busRegion    devRegion;
    logic [1:0]  devOffset;
    logic [31:0] devWData;
    logic        devWrite;
    logic [31:0] devRData;

    // Timers
    logic [1:0]  timer0Offset;
    logic [31:0] timer0WData;
    logic        timer0Write;
    logic [31:0] timer0RData;
    logic        timer0Irq;
    logic [1:0]  timer1Offset;
    logic [31:0] timer1WData;
    logic        timer1Write;
    logic [31:0] timer1RData;
    logic        timer1Irq;

    // Port names match the wires above
    northBridge nbridge (.*);

    dataMem dm (
        .clk    (clk),
        .reset  (reset),
        .addr   (memAddr),
        .wData  (memWData),
        .byteEn (memByteEn),
        .write  (memWrite),
        .rData  (memRData)
    );

    southBridge sbridge (.*);

    timer timer0 (
        .clk       (clk),
        .reset     (reset),
        .regOffset (timer0Offset),
        .wData     (timer0WData),
        .write     (timer0Write),
        .rData     (timer0RData),
        .irq       (timer0Irq)
    );

    timer timer1 (
        .clk       (clk),
        .reset     (reset),
        .regOffset (timer1Offset),
        .wData     (timer1WData),
        .write     (timer1Write),
        .rData     (timer1RData),
        .irq       (timer1Irq)
    );

endmodule

// ==== tbMicroSystem.sv ====
`include "microSystem_defines.svh"

module tbMicroSystem import busPkg::*, timerPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Test lengths, also used to size the watchdog
    localparam int resetCycles = 8;
    localparam int arbRounds = 6;
    localparam int arbBase = 64;
    localparam int memWords = 16;
    localparam int memOps = 40;
    localparam int maxStall = 3;
    localparam int oneShotPreset = 20;
    localparam int reloadPreset = 5;
    localparam int reloadCycles = 60;
    localparam int extCycles = 8;
    localparam int timerAccesses = 30;
    localparam int accessCycles = 12;
    localparam int totalAccesses = 4 * arbRounds + memWords + memOps + timerAccesses;
    localparam int watchdogCycles = 2 * (resetCycles + totalAccesses * accessCycles
                                         + oneShotPreset + reloadCycles + extCycles);
    // Grant wait bound, one other access plus the own grant edge
    localparam int arbMaxWait = 4;

    logic                   clk;
    logic                   reset;
    logic                   extInterrupt;
    logic [`HWINT_BITS-1:0] hwInt;
    logic                   reqValid [2];
    logic                   reqReady [2];
    busOp                   reqOp [2];
    logic [31:0]            reqAddr [2];
    logic [31:0]            reqWData [2];
    logic [3:0]             reqByteEn [2];
    logic                   respValid [2];
    logic                   respReady [2];
    logic [31:0]            respRData [2];
    logic                   respError [2];

    logic [31:0] refMem [`DM_WORDS];
    int          grantLog [$];
    logic        reloadWatch;
    integer      seed = 32'hae1;

    microSystem UUT (
        .clk          (clk),
        .reset        (reset),
        .extInterrupt (extInterrupt),
        .hwInt        (hwInt),
        .reqValid0    (reqValid[0]),
        .reqReady0    (reqReady[0]),
        .reqOp0       (reqOp[0]),
        .reqAddr0     (reqAddr[0]),
        .reqWData0    (reqWData[0]),
        .reqByteEn0   (reqByteEn[0]),
        .respValid0   (respValid[0]),
        .respReady0   (respReady[0]),
        .respRData0   (respRData[0]),
        .respError0   (respError[0]),
        .reqValid1    (reqValid[1]),
        .reqReady1    (reqReady[1]),
        .reqOp1       (reqOp[1]),
        .reqAddr1     (reqAddr[1]),
        .reqWData1    (reqWData[1]),
        .reqByteEn1   (reqByteEn[1]),
        .respValid1   (respValid[1]),
        .respReady1   (respReady[1]),
        .respRData1   (respRData[1]),
        .respError1   (respError[1])
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("Fail %s: expected %h, got %h", name, expected, actual);
        abortRun();
    endtask

    task automatic reportProblem(input string msg);
        $display("%s", msg);
        abortRun();
    endtask

    function automatic logic [31:0] randomWord();
        return $random(seed);
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] byteEn);
        logic [31:0] merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (byteEn[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Expected decode from the address map
    function automatic logic isUnmapped(input logic [31:0] addr);
        logic inTimer0;
        logic inTimer1;
        inTimer0 = (addr >= `TIMER0_BASE) && (addr < `TIMER0_BASE + 12);
        inTimer1 = (addr >= `TIMER1_BASE) && (addr < `TIMER1_BASE + 12);
        return !((addr < `DM_BYTES) || inTimer0 || inTimer1);
    endfunction

    function automatic logic [31:0] timerAddr(input logic [31:0] base, input logic [1:0] offset);
        return base + {28'b0, offset, 2'b00};
    endfunction

    function automatic logic [31:0] ctrlWord(input logic enable, input timerMode mode,
                                             input logic im);
        logic [31:0] word;
        word = '0;
        word[`CTRL_ENABLE] = enable;
        word[`CTRL_MODE_HI:`CTRL_MODE_LO] = mode;
        word[`CTRL_IM] = im;
        return word;
    endfunction

    task automatic checkHeld(input int port, input logic [31:0] data, input logic err);
        assert (respValid[port]) else reportProblem("respValid dropped before the handshake");
        assert (respRData[port] === data) else
            reportMismatch($sformatf("respRData%0d", port), data, respRData[port]);
        assert (respError[port] === err) else
            reportMismatch($sformatf("respError%0d", port), err, respError[port]);
    endtask

    // One request and its response; called in the low clock phase or waits for it
    task automatic busAccess(input int port, input busOp op, input logic [31:0] addr,
                             input logic [31:0] wData, input logic [3:0] byteEn,
                             input int stall, input int maxWait,
                             output logic [31:0] rData, output logic err);
        int          waited;
        int          latency;
        logic [31:0] heldData;
        logic        heldErr;
        if (clk) begin
            @(negedge clk);
        end
        reqValid[port]  = 1'b1;
        reqOp[port]     = op;
        reqAddr[port]   = addr;
        reqWData[port]  = wData;
        reqByteEn[port] = byteEn;
        respReady[port] = (stall == 0);
        waited = 1;
        @(posedge clk);
        while (!reqReady[port]) begin
            waited++;
            @(posedge clk);
        end
        grantLog.push_back(port);
        assert (maxWait == 0 || waited <= maxWait) else
            reportProblem($sformatf("Port %0d waited %0d cycles for a grant", port, waited));
        @(negedge clk);
        reqValid[port] = 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!respValid[port]);
        assert (latency == 2) else
            reportMismatch($sformatf("respValid%0d latency", port), 2, latency);
        heldData = respRData[port];
        heldErr  = respError[port];
        // Back-pressure, response must not move
        if (stall > 0) begin
            repeat (stall) begin
                @(posedge clk);
                checkHeld(port, heldData, heldErr);
            end
            @(negedge clk);
            respReady[port] = 1'b1;
            @(posedge clk);
            checkHeld(port, heldData, heldErr);
        end
        @(negedge clk);
        respReady[port] = 1'b0;
        rData = heldData;
        err   = heldErr;
        assert (err === isUnmapped(addr)) else
            reportMismatch($sformatf("respError%0d", port), isUnmapped(addr), err);
        if (op == opWrite || err) begin
            assert (rData === 32'h0) else
                reportMismatch($sformatf("respRData%0d", port), 32'h0, rData);
        end
    endtask

    task automatic verifyWord(input int port, input int w, input int stall);
        logic [31:0] rData;
        logic        err;
        busAccess(port, opRead, w * 4, '0, 4'h0, stall, 0, rData, err);
        assert (rData === refMem[w]) else
            reportMismatch($sformatf("respRData%0d word %0d", port, w), refMem[w], rData);
    endtask

    task automatic arbitrationTest();
        logic [31:0] arbData [2][arbRounds];
        int          start;
        start = grantLog.size();
        for (int i = 0; i < arbRounds; i++) begin
            arbData[0][i] = randomWord();
            arbData[1][i] = randomWord();
            refMem[arbBase + 2 * i]     = arbData[0][i];
            refMem[arbBase + 2 * i + 1] = arbData[1][i];
        end
        fork
            begin
                logic [31:0] rd0;
                logic        err0;
                for (int i = 0; i < arbRounds; i++) begin
                    busAccess(0, opWrite, (arbBase + 2 * i) * 4, arbData[0][i], 4'hF, 0,
                              arbMaxWait, rd0, err0);
                end
            end
            begin
                logic [31:0] rd1;
                logic        err1;
                for (int i = 0; i < arbRounds; i++) begin
                    busAccess(1, opWrite, (arbBase + 2 * i + 1) * 4, arbData[1][i], 4'hF, 0,
                              arbMaxWait, rd1, err1);
                end
            end
        join
        // Port 0 has priority straight after reset
        assert (grantLog[start] == 0) else reportMismatch("first grant", 0, grantLog[start]);
        for (int i = start + 1; i < grantLog.size(); i++) begin
            assert (grantLog[i] != grantLog[i-1]) else
                reportProblem("Grants did not alternate between the two ports");
        end
        for (int i = 0; i < 2 * arbRounds; i++) begin
            verifyWord(i % 2, arbBase + i, 0);
        end
    endtask

    task automatic memoryTest();
        logic [31:0] rData;
        logic [31:0] data;
        logic [3:0]  byteEn;
        logic        err;
        int          port;
        int          w;
        int          stall;
        for (int i = 0; i < memWords; i++) begin
            data = randomWord();
            busAccess(i % 2, opWrite, i * 4, data, 4'hF, 0, 0, rData, err);
            refMem[i] = data;
        end
        for (int i = 0; i < memOps; i++) begin
            port  = randomWord() % 2;
            w     = randomWord() % memWords;
            stall = randomWord() % (maxStall + 1);
            if (randomWord() % 2) begin
                data   = randomWord();
                byteEn = randomWord();
                busAccess(port, opWrite, w * 4, data, byteEn, stall, 0, rData, err);
                refMem[w] = mergeBytes(refMem[w], data, byteEn);
            end else begin
                verifyWord(port, w, stall);
            end
        end
    endtask

    task automatic waitHwInt(input int bitIdx, input int limit);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!hwInt[bitIdx]) begin
            cycles++;
            assert (cycles <= limit) else
                reportProblem($sformatf("hwInt bit %0d never rose", bitIdx));
            @(posedge clk);
        end
    endtask

    task automatic oneShotTest();
        logic [31:0] rData;
        logic        err;
        busAccess(0, opWrite, timerAddr(`TIMER0_BASE, `TIMER_PRESET), oneShotPreset, 4'hF, 0, 0,
                  rData, err);
        busAccess(1, opWrite, timerAddr(`TIMER0_BASE, `TIMER_CTRL),
                  ctrlWord(1'b1, modeOneShot, 1'b1), 4'hF, 0, 0, rData, err);
        assert (!hwInt[`HWINT_TIMER0]) else reportMismatch("hwInt[0]", 0, hwInt[`HWINT_TIMER0]);
        busAccess(0, opRead, timerAddr(`TIMER0_BASE, `TIMER_COUNT), '0, 4'h0, 1, 0, rData, err);
        assert (rData <= oneShotPreset) else reportMismatch("timer0 count", oneShotPreset, rData);
        waitHwInt(`HWINT_TIMER0, oneShotPreset + 10);
        busAccess(1, opRead, timerAddr(`TIMER0_BASE, `TIMER_COUNT), '0, 4'h0, 0, 0, rData, err);
        assert (rData === 32'h0) else reportMismatch("timer0 count", 32'h0, rData);
        @(posedge clk);
        assert (hwInt[`HWINT_TIMER0]) else reportMismatch("hwInt[0]", 1, hwInt[`HWINT_TIMER0]);
        // IM stays set, so only the ctrl write itself can drop the interrupt
        busAccess(0, opWrite, timerAddr(`TIMER0_BASE, `TIMER_CTRL),
                  ctrlWord(1'b0, modeOneShot, 1'b1), 4'hF, 0, 0, rData, err);
        @(posedge clk);
        assert (!hwInt[`HWINT_TIMER0]) else reportMismatch("hwInt[0]", 0, hwInt[`HWINT_TIMER0]);
    endtask

    task automatic reloadTest();
        logic [31:0] rData;
        logic        err;
        int          pulses;
        busAccess(1, opWrite, timerAddr(`TIMER1_BASE, `TIMER_PRESET), reloadPreset, 4'hF, 0, 0,
                  rData, err);
        busAccess(0, opWrite, timerAddr(`TIMER1_BASE, `TIMER_CTRL),
                  ctrlWord(1'b1, modeReload, 1'b1), 4'hF, 0, 0, rData, err);
        reloadWatch = 1'b1;
        pulses = 0;
        fork
            repeat (reloadCycles) begin
                @(posedge clk);
                if (hwInt[`HWINT_TIMER1]) begin
                    pulses++;
                end
            end
            for (int i = 0; i < 6; i++) begin
                logic [31:0] count;
                logic        countErr;
                busAccess(i % 2, opRead, timerAddr(`TIMER1_BASE, `TIMER_COUNT), '0, 4'h0,
                          i % 3, 0, count, countErr);
                assert (count <= reloadPreset) else
                    reportMismatch("timer1 count", reloadPreset, count);
            end
        join
        assert (pulses >= reloadCycles / (2 * (reloadPreset + 1))) else
            reportProblem($sformatf("Timer1 gave only %0d interrupt pulses", pulses));
        if (clk) begin
            @(negedge clk);
        end
        reloadWatch = 1'b0;
        busAccess(1, opWrite, timerAddr(`TIMER1_BASE, `TIMER_CTRL), 32'h0, 4'hF, 0, 0, rData, err);
    endtask

    task automatic extAndErrorTest();
        logic [31:0] rData;
        logic [31:0] rnd;
        logic        err;
        for (int i = 0; i < extCycles; i++) begin
            @(negedge clk);
            rnd = randomWord();
            extInterrupt = rnd[0];
            @(posedge clk);
            assert (hwInt[`HWINT_EXT] === extInterrupt) else
                reportMismatch("hwInt[2]", extInterrupt, hwInt[`HWINT_EXT]);
        end
        @(negedge clk);
        extInterrupt = 1'b0;
        busAccess(0, opRead, 32'h0000_2000, '0, 4'h0, 0, 0, rData, err);
        assert (err) else reportProblem("Read of an unmapped address gave no error");
        // Low bits alias word 3 of the data memory
        busAccess(1, opWrite, 32'h0000_100C, randomWord(), 4'hF, 2, 0, rData, err);
        assert (err) else reportProblem("Write above the data memory gave no error");
        // Fourth word of the timer0 window is outside the map
        busAccess(0, opWrite, timerAddr(`TIMER0_BASE, 2'd3), 32'hF, 4'hF, 1, 0, rData, err);
        assert (err) else reportProblem("Write past the timer0 registers gave no error");
        verifyWord(1, 3, 0);
        busAccess(0, opRead, timerAddr(`TIMER0_BASE, `TIMER_CTRL), '0, 4'h0, 0, 0, rData, err);
        assert (rData === ctrlWord(1'b0, modeOneShot, 1'b1)) else
            reportMismatch("timer0 ctrl", ctrlWord(1'b0, modeOneShot, 1'b1), rData);
        busAccess(1, opRead, timerAddr(`TIMER0_BASE, `TIMER_PRESET), '0, 4'h0, 0, 0, rData, err);
        assert (rData === oneShotPreset) else reportMismatch("timer0 preset", oneShotPreset, rData);
        busAccess(0, opRead, timerAddr(`TIMER1_BASE, `TIMER_PRESET), '0, 4'h0, 0, 0, rData, err);
        assert (rData === reloadPreset) else reportMismatch("timer1 preset", reloadPreset, rData);
    endtask

    // Both ports blocked while a response waits
    assert property (@(posedge clk) disable iff (reset)
        (respValid[0] || respValid[1]) |-> !(reqReady[0] || reqReady[1]))
        else reportProblem("reqReady was high while a response was pending");
    assert property (@(posedge clk) disable iff (reset) respError[0] |-> (respRData[0] == 0))
        else reportMismatch("respRData0", 32'h0, respRData[0]);
    assert property (@(posedge clk) disable iff (reset) respError[1] |-> (respRData[1] == 0))
        else reportMismatch("respRData1", 32'h0, respRData[1]);
    assert property (@(posedge clk) disable iff (reset) hwInt[`HWINT_EXT] == extInterrupt)
        else reportMismatch("hwInt[2]", extInterrupt, hwInt[`HWINT_EXT]);
    assert property (@(posedge clk) disable iff (reset) hwInt[`HWINT_BITS-1:3] == 0)
        else reportMismatch("hwInt[5:3]", 32'h0, hwInt[`HWINT_BITS-1:3]);
    assert property (@(posedge clk) disable iff (reset)
        (reloadWatch && hwInt[`HWINT_TIMER1]) |=> !hwInt[`HWINT_TIMER1])
        else reportProblem("Timer1 interrupt pulse lasted more than one cycle");

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        reportProblem("Timeout, the run did not finish in the expected time");
    end

    initial begin
        reset        = 1'b1;
        extInterrupt = 1'b0;
        reloadWatch  = 1'b0;
        for (int p = 0; p < 2; p++) begin
            reqValid[p]  = 1'b0;
            reqOp[p]     = opRead;
            reqAddr[p]   = '0;
            reqWData[p]  = '0;
            reqByteEn[p] = '0;
            respReady[p] = 1'b0;
        end
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        assert (reqReady[0] && reqReady[1] && !respValid[0] && !respValid[1]
                && !respError[0] && !respError[1] && hwInt == 0)
            else reportProblem("Outputs after reset are not at their idle values");
        arbitrationTest();
        memoryTest();
        oneShotTest();
        reloadTest();
        extAndErrorTest();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== microSystem.f ====
+incdir+.
busPkg.sv
timerPkg.sv
dataMem.sv
timer.sv
northBridge.sv
southBridge.sv
microSystem.sv
tbMicroSystem.sv
